/* vlog.f */
+incdir+verilog
verilog/mul_pkg.sv
verilog/partial_products.sv
verilog/compress_row_4_2.sv
verilog/reduce_stage.sv
verilog/prefix_adder.sv
verilog/dadda_mul_top.sv
tb/dadda_mul_sva.sv
tb/tb_dadda_mul.sv

/* run_sim.sh */
#!/bin/sh
# build and run the multiplier testbench with Verilator

verilator --binary --timing --assert --top-module tb_dadda_mul -f vlog.f -o tb_dadda_mul \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_dadda_mul > sim.log 2>&1
cat sim.log

grep -q "^TEST PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb/tb_dadda_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dadda_mul
	import mul_pkg::*;
();

	localparam int          RESET_CYCLES = 16;
	localparam int          RANDOM_REQS  = 300;
	localparam int          SPARSE_REQS  = 30;
	localparam int          MAX_GAP      = 6;
	localparam int          CYCLE_LIMIT  = 1000;
	localparam logic [31:0] SEED         = 32'd87204;

	logic     clk;
	logic     rst_n;
	mul_req_t req;
	mul_rsp_t rsp;

	logic [31:0] rng_state;

	int cycle_count  = 0;
	int expect_rsp   = 0;
	int rsp_count    = 0;
	int count_errors = 0;
	int tests_run    = 0;
	int tests_failed = 0;

	dadda_mul_top u_dut (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.rsp   (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run was still going after %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (rsp.valid) begin
			rsp_count <= rsp_count + 1;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_random(output logic [31:0] value);
		rng_state = lcg_next(rng_state);
		value = rng_state;
	endtask

	task automatic send_req(input operand_t op_a, input operand_t op_b);
		@(posedge clk);
		req <= '{valid: 1'b1, a: op_a, b: op_b};
		expect_rsp++;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			req.valid <= 1'b0;
		end
	endtask

	// wait until every request has come back
	task automatic drain();
		idle_cycles(1);
		while (rsp_count < expect_rsp) begin
			@(posedge clk);
		end
		idle_cycles(2);
		if (rsp_count != expect_rsp) begin
			count_errors++;
			$display("response count is wrong: %0d responses for %0d requests",
				rsp_count, expect_rsp);
		end
	endtask

	function automatic int error_total();
		return u_dut.u_sva.fail_count + count_errors;
	endfunction

	task automatic finish_test(input string name, input int errors_before);
		int errors;
		errors = error_total() - errors_before;
		tests_run++;
		if (errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors);
		end
	endtask

	initial begin
		int          base;
		int          seen;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;

		rst_n = 1'b0;
		req = '0;
		rng_state = SEED;

		// nothing may come out of reset on its own
		base = error_total();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		idle_cycles(8);
		finish_test("reset_quiet", base);

		base = error_total();
		send_req(16'h0000, 16'h0000);
		send_req(16'h0000, 16'hffff);
		send_req(16'h0001, 16'hffff);
		send_req(16'hffff, 16'hffff);
		send_req(16'h8000, 16'h8000);
		send_req(16'haaaa, 16'h5555);
		drain();
		finish_test("corner_operands", base);

		// full pipeline, one request per clock
		base = error_total();
		for (int i = 0; i < RANDOM_REQS; i++) begin
			next_random(r1);
			next_random(r2);
			send_req(r1[31:16], r2[31:16]);
		end
		drain();
		finish_test("back_to_back", base);

		base = error_total();
		for (int i = 0; i < SPARSE_REQS; i++) begin
			next_random(r1);
			next_random(r2);
			next_random(r3);
			send_req(r1[31:16], r2[31:16]);
			idle_cycles(int'(r3[31:16] % (MAX_GAP + 1)));
		end
		drain();
		finish_test("sparse_strobes", base);

		// three requests caught in the pipe by reset
		base = error_total();
		seen = rsp_count;
		for (int i = 0; i < 3; i++) begin
			next_random(r1);
			next_random(r2);
			send_req(r1[31:16], r2[31:16]);
		end
		@(posedge clk);
		req.valid <= 1'b0;
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		idle_cycles(8);
		expect_rsp -= 3;
		if (rsp_count != seen) begin
			count_errors++;
			$display("reset in flight: a discarded request still produced a response");
		end
		send_req(16'h1234, 16'h4321);
		drain();
		finish_test("reset_in_flight", base);

		$display("tests run %0d, tests failed %0d, assertion failures %0d, other errors %0d",
			tests_run, tests_failed, u_dut.u_sva.fail_count, count_errors);
		if (tests_failed == 0 && error_total() == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/dadda_mul_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module dadda_mul_sva
	import mul_pkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input mul_req_t req,
	input mul_rsp_t rsp
);

	localparam int LAT = `MUL_LATENCY;

	int fail_count = 0;

	// request copy, one slot per pipeline register
	logic [LAT-1:0]     valid_pipe;
	operand_t [LAT-1:0] a_pipe;
	operand_t [LAT-1:0] b_pipe;

	product_t expected_product;
	product_t last_product;
	logic     have_product;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[LAT-2:0], req.valid};
		end
	end

	always_ff @(posedge clk) begin
		a_pipe <= {a_pipe[LAT-2:0], req.a};
		b_pipe <= {b_pipe[LAT-2:0], req.b};
	end

	assign expected_product = product_t'(a_pipe[LAT-1]) * product_t'(b_pipe[LAT-1]);

	// last delivered product, forgotten on reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			have_product <= 1'b0;
		end else if (rsp.valid) begin
			have_product <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp.valid) begin
			last_product <= rsp.product;
		end
	end

	a_product: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.valid |-> rsp.product == expected_product)
	else begin
		fail_count++;
		$error("CHECK FAILED rsp.product: got %h expected %h",
			$sampled(rsp.product), $sampled(expected_product));
	end

	a_valid_timing: assert property (@(posedge clk)
		rsp.valid == valid_pipe[LAT-1])
	else begin
		fail_count++;
		$error("CHECK FAILED rsp.valid: got %h expected %h",
			$sampled(rsp.valid), $sampled(valid_pipe[LAT-1]));
	end

	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> !rsp.valid)
	else begin
		fail_count++;
		$error("CHECK FAILED rsp.valid in reset: got %h expected 0", $sampled(rsp.valid));
	end

	// product must hold between responses
	a_product_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(!rsp.valid && have_product) |-> rsp.product == last_product)
	else begin
		fail_count++;
		$error("CHECK FAILED rsp.product while idle: got %h expected %h",
			$sampled(rsp.product), $sampled(last_product));
	end

endmodule

bind dadda_mul_top dadda_mul_sva u_sva (
	.clk   (clk),
	.rst_n (rst_n),
	.req   (req),
	.rsp   (rsp)
);

`default_nettype wire

/* verilog/dadda_mul_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module dadda_mul_top
	import mul_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mul_req_t req,
	output mul_rsp_t rsp
);

	// row banks between the levels
	product_t [`MUL_PP_ROWS-1:0]   pp_rows;
	product_t [`MUL_PP_ROWS/2-1:0] l1_rows;
	product_t [`MUL_PP_ROWS/4-1:0] l2_rows;
	product_t [1:0]                l3_rows;

	logic l1_valid;
	logic l2_valid;
	logic l3_valid;

	partial_products u_pp (
		.a    (req.a),
		.b    (req.b),
		.rows (pp_rows)
	);

	// 16 -> 8
	reduce_stage #(
		.IN_ROWS (`MUL_PP_ROWS)
	) u_reduce_l1 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (req.valid),
		.in_rows   (pp_rows),
		.out_valid (l1_valid),
		.out_rows  (l1_rows)
	);

	// 8 -> 4
	reduce_stage #(
		.IN_ROWS (`MUL_PP_ROWS/2)
	) u_reduce_l2 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (l1_valid),
		.in_rows   (l1_rows),
		.out_valid (l2_valid),
		.out_rows  (l2_rows)
	);

	// 4 -> 2
	reduce_stage #(
		.IN_ROWS (`MUL_PP_ROWS/4)
	) u_reduce_l3 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (l2_valid),
		.in_rows   (l2_rows),
		.out_valid (l3_valid),
		.out_rows  (l3_rows)
	);

	// last two rows summed, fourth register
	prefix_adder u_add (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (l3_valid),
		.in_rows  (l3_rows),
		.rsp      (rsp)
	);

endmodule

`default_nettype wire

/* verilog/prefix_adder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module prefix_adder
	import mul_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,
	input  logic           in_valid,
	input  product_t [1:0] in_rows,
	output mul_rsp_t       rsp
);

	localparam int W      = `MUL_PRODUCT_W;
	localparam int LEVELS = $clog2(W);

	// generate and propagate at each doubling level
	wire product_t gen_lvl  [0:LEVELS];
	wire product_t prop_lvl [0:LEVELS];

	product_t sum;
	product_t carry_in;

	logic     rsp_valid;
	product_t rsp_product;

	assign gen_lvl[0]  = in_rows[0] & in_rows[1];
	assign prop_lvl[0] = in_rows[0] ^ in_rows[1];

	for (genvar l = 0; l < LEVELS; l++) begin : g_level
		localparam int D = 1 << l;

		for (genvar i = 0; i < W; i++) begin : g_bit
			if (i >= D) begin : g_cell
				// combine with the group D bits below
				assign gen_lvl[l+1][i] = gen_lvl[l][i] |
					(prop_lvl[l][i] & gen_lvl[l][i-D]);
				assign prop_lvl[l+1][i] = prop_lvl[l][i] & prop_lvl[l][i-D];
			end else begin : g_pass
				// already spans down to bit 0
				assign gen_lvl[l+1][i]  = gen_lvl[l][i];
				assign prop_lvl[l+1][i] = prop_lvl[l][i];
			end
		end
	end

	// carry into bit i is the group generate of bits i-1..0
	assign carry_in = {gen_lvl[LEVELS][W-2:0], 1'b0};
	assign sum      = prop_lvl[0] ^ carry_in;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= in_valid;
		end
	end

	// product holds between responses
	always_ff @(posedge clk) begin
		if (in_valid) begin
			rsp_product <= sum;
		end
	end

	assign rsp = '{valid: rsp_valid, product: rsp_product};

endmodule

`default_nettype wire

/* verilog/reduce_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module reduce_stage
	import mul_pkg::*;
#(
	parameter int IN_ROWS = 16
)
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_valid,
	input  product_t [IN_ROWS-1:0]        in_rows,
	output logic                          out_valid,
	output product_t [IN_ROWS/2-1:0]      out_rows
);

	localparam int OUT_ROWS = IN_ROWS / 2;
	localparam int GROUPS   = IN_ROWS / 4;

	product_t [OUT_ROWS-1:0] next_rows;

	// four rows in, sum and carry out, per group
	for (genvar g = 0; g < GROUPS; g++) begin : g_group
		compress_row_4_2 u_compress (
			.in_rows   (in_rows[4*g+3:4*g]),
			.sum_row   (next_rows[2*g]),
			.carry_row (next_rows[2*g+1])
		);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// data only moves with a valid request
	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_rows <= next_rows;
		end
	end

endmodule

`default_nettype wire

/* verilog/compress_row_4_2.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module compress_row_4_2
	import mul_pkg::*;
(
	input  product_t [3:0] in_rows,
	output product_t       sum_row,
	output product_t       carry_row
);

	localparam int W = `MUL_PRODUCT_W;

	// lateral carry chain between neighbouring slices
	logic [W:0] chain;

	// second full adder carries, weight 2^(i+1)
	product_t slice_carry;

	assign chain[0] = 1'b0;

	for (genvar i = 0; i < W; i++) begin : g_slice
		logic x1;
		logic x2;
		logic x3;
		logic x4;
		logic s1;

		assign x1 = in_rows[0][i];
		assign x2 = in_rows[1][i];
		assign x3 = in_rows[2][i];
		assign x4 = in_rows[3][i];

		// first full adder, carry goes sideways
		assign s1 = x1 ^ x2 ^ x3;
		assign chain[i+1] = (x1 & x2) | (x1 & x3) | (x2 & x3);

		// second full adder takes the incoming chain bit
		assign sum_row[i] = s1 ^ x4 ^ chain[i];
		assign slice_carry[i] = (s1 & x4) | (s1 & chain[i]) | (x4 & chain[i]);
	end

	// product fits in W bits so the top carries are dropped
	assign carry_row = {slice_carry[W-2:0], 1'b0};

endmodule

`default_nettype wire

/* verilog/partial_products.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module partial_products
	import mul_pkg::*;
(
	input  operand_t                         a,
	input  operand_t                         b,
	output product_t [`MUL_PP_ROWS-1:0]      rows
);

	// row k is a gated by b[k], weighted by 2^k
	for (genvar k = 0; k < `MUL_PP_ROWS; k++) begin : g_row
		operand_t gated;
		product_t wide;

		assign gated = a & {`MUL_OPERAND_W{b[k]}};

		// zero extension to product width
		assign wide = product_t'(gated);

		assign rows[k] = wide << k;
	end

endmodule

`default_nettype wire

/* verilog/mul_pkg.sv */
`default_nettype none

`include "mul_config.svh"

package mul_pkg;

	typedef logic [`MUL_OPERAND_W-1:0] operand_t;

	// also one row of the reduction tree
	typedef logic [`MUL_PRODUCT_W-1:0] product_t;

	typedef struct packed {
		logic     valid;
		operand_t a;
		operand_t b;
	} mul_req_t;

	typedef struct packed {
		logic     valid;
		product_t product;
	} mul_rsp_t;

endpackage

`default_nettype wire

/* verilog/mul_config.svh */
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// operand and product widths
`define MUL_OPERAND_W 16
`define MUL_PRODUCT_W 32

// one partial-product row per multiplier bit
`define MUL_PP_ROWS 16

// request to response, in clock cycles
`define MUL_LATENCY 4

`endif
